/* verilog/dcache_defs.svh */
//////////////////////////////////////////////////
// Data cache geometry and address map macros
//////////////////////////////////////////////////

`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Bus widths on both Wishbone ports
`define DCACHE_ADDR_W    32
`define DCACHE_DATA_W    32
`define DCACHE_SEL_W     4

// Line payload and words per line
`define DCACHE_LINE_W    128
`define DCACHE_BEATS     4

// Direct-mapped geometry, tag takes the remaining upper bits
`define DCACHE_DEPTH     64
`define DCACHE_INDEX_W   6
`define DCACHE_OFFSET_W  4
`define DCACHE_TAG_W     22

// Everything from here up bypasses the cache
`define DCACHE_IO_BASE   32'hF000_0000

`endif

/* verilog/dcache_pkg.sv */
//////////////////////////////////////////////////
// Shared bus structs, line type and FSM enums
//////////////////////////////////////////////////

`include "dcache_defs.svh"

package dcache_pkg;

    // One Wishbone request, handshake bits travel separately
    typedef struct packed {
        logic [`DCACHE_ADDR_W-1:0] adr;
        logic [`DCACHE_DATA_W-1:0] dat;
        logic [`DCACHE_SEL_W-1:0]  sel;
        logic                      we;
    } wb_req_t;

    typedef struct packed {
        logic [`DCACHE_DATA_W-1:0] dat;
    } wb_rsp_t;

    // Jobs handed to the memory controller
    typedef enum logic [1:0] {
        MEM_READ_WORD,
        MEM_WRITE_WORD,
        MEM_FILL_LINE
    } mem_op_e;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_LOOKUP,
        ST_FILL,
        ST_MEM,
        ST_ACK
    } ctrl_state_e;

    typedef logic [`DCACHE_BEATS-1:0][`DCACHE_DATA_W-1:0] line_t;

endpackage

/* verilog/dcache_blocks.sv */
//////////////////////////////////////////////////
// Valid, tag and data arrays with post-reset sweep
//////////////////////////////////////////////////

`include "dcache_defs.svh"

module dcache_blocks import dcache_pkg::*; (
    input  logic                      aclk,
    input  logic                      reset,
    input  logic [`DCACHE_ADDR_W-1:0] lookup_addr,
    input  logic                      upd_wen,
    input  wb_req_t                   upd_req,
    input  logic                      fill_wen,
    input  logic [`DCACHE_ADDR_W-1:0] fill_addr,
    input  line_t                     fill_line,
    output logic                      hit,
    output wb_rsp_t                   hit_word,
    output logic                      cache_ready
);

    logic [`DCACHE_DEPTH-1:0]    valid;
    logic [`DCACHE_TAG_W-1:0]    tag_mem [`DCACHE_DEPTH];
    line_t                       data_mem [`DCACHE_DEPTH];
    logic [`DCACHE_ADDR_W-1:0]   look_q;
    logic [`DCACHE_INDEX_W-1:0]  clr_idx;
    logic [`DCACHE_INDEX_W-1:0]  look_idx;
    logic [`DCACHE_INDEX_W-1:0]  upd_idx;
    logic [`DCACHE_INDEX_W-1:0]  fill_idx;
    logic [`DCACHE_OFFSET_W-3:0] look_word;
    logic [`DCACHE_OFFSET_W-3:0] upd_word;
    logic                        upd_match;

    // Address split: tag | index | word | byte
    assign look_idx  = look_q[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign look_word = look_q[`DCACHE_OFFSET_W-1:2];
    assign upd_idx   = upd_req.adr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign upd_word  = upd_req.adr[`DCACHE_OFFSET_W-1:2];
    assign fill_idx  = fill_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

    assign upd_match = valid[upd_idx]
                    && (tag_mem[upd_idx] == upd_req.adr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W]);

    // Lookup result, one cycle after the address is presented
    assign hit = valid[look_idx]
              && (tag_mem[look_idx] == look_q[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W]);
    assign hit_word.dat = data_mem[look_idx][look_word];

    //////////////////////////////////////////////////
    // Valid bits and clearing sweep
    //////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (reset) begin
            clr_idx     <= '0;
            cache_ready <= 1'b0;
        end else if (!cache_ready) begin
            // One line per cycle until the last index is cleared
            valid[clr_idx] <= 1'b0;
            clr_idx        <= clr_idx + 1'b1;
            if (clr_idx == `DCACHE_INDEX_W'(`DCACHE_DEPTH - 1)) begin
                cache_ready <= 1'b1;
            end
        end else if (fill_wen) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Tag and data storage
    //////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        look_q <= lookup_addr;
        if (fill_wen) begin
            tag_mem[fill_idx]  <= fill_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
            data_mem[fill_idx] <= fill_line;
        end else if (upd_wen && upd_match) begin
            // Write hit, merge only the selected bytes
            for (int b = 0; b < `DCACHE_SEL_W; b++) begin
                if (upd_req.sel[b]) begin
                    data_mem[upd_idx][upd_word][8*b +: 8] <= upd_req.dat[8*b +: 8];
                end
            end
        end
    end

endmodule

/* verilog/dcache_ctrl.sv */
//////////////////////////////////////////////////
// Request engine: hit/miss, uncached and write-through
//////////////////////////////////////////////////

`include "dcache_defs.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                      aclk,
    input  logic                      reset,
    // CPU side
    input  logic                      cpu_cyc,
    input  logic                      cpu_stb,
    input  wb_req_t                   cpu_req,
    output logic                      cpu_ack,
    output wb_rsp_t                   cpu_rsp,
    // Cache blocks
    input  logic                      cache_ready,
    input  logic                      hit,
    input  wb_rsp_t                   hit_word,
    output logic [`DCACHE_ADDR_W-1:0] lookup_addr,
    output logic                      upd_wen,
    output wb_req_t                   upd_req,
    // Memory controller
    output logic                      op_valid,
    output mem_op_e                   op,
    output wb_req_t                   op_req,
    input  logic                      op_done,
    input  wb_rsp_t                   op_rdata
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    wb_req_t     req_q;
    wb_rsp_t     rsp_q;
    logic        cpu_io;
    logic        req_io;

    // Uncached region check, on the bus and on the held request
    assign cpu_io = (cpu_req.adr >= `DCACHE_IO_BASE);
    assign req_io = (req_q.adr >= `DCACHE_IO_BASE);

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_INIT: begin
                // Hold off requests until the sweep is done
                if (cache_ready) begin
                    state_d = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (cpu_cyc && cpu_stb) begin
                    state_d = (cpu_req.we || cpu_io) ? ST_MEM : ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                state_d = hit ? ST_ACK : ST_FILL;
            end
            ST_FILL, ST_MEM: begin
                if (op_done) begin
                    state_d = ST_ACK;
                end
            end
            ST_ACK: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_INIT;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state_q <= ST_INIT;
        end else begin
            state_q <= state_d;
        end
    end

    // Request and response holding registers
    always_ff @(posedge aclk) begin
        if (state_q == ST_IDLE && cpu_cyc && cpu_stb) begin
            req_q <= cpu_req;
        end
        if (state_q == ST_LOOKUP && hit) begin
            rsp_q <= hit_word;
        end else if ((state_q == ST_FILL || state_q == ST_MEM) && op_done) begin
            rsp_q <= op_rdata;  // fill word or uncached read data
        end
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    assign cpu_ack = (state_q == ST_ACK);
    assign cpu_rsp = rsp_q;

    // Blocks register this, so the IDLE cycle address is looked up in LOOKUP
    assign lookup_addr = cpu_req.adr;

    // Cached bytes follow the memory write, blocks drop it on a tag mismatch
    assign upd_wen = (state_q == ST_MEM) && op_done && req_q.we && !req_io;
    assign upd_req = req_q;

    assign op_valid = (state_q == ST_FILL) || (state_q == ST_MEM);
    assign op_req   = req_q;

    always_comb begin
        if (state_q == ST_FILL) begin
            op = MEM_FILL_LINE;
        end else if (req_q.we) begin
            op = MEM_WRITE_WORD;
        end else begin
            op = MEM_READ_WORD;
        end
    end

endmodule

/* verilog/dcache_memctrl.sv */
//////////////////////////////////////////////////
// Wishbone master for word cycles and line fills
//////////////////////////////////////////////////

`include "dcache_defs.svh"

module dcache_memctrl import dcache_pkg::*; (
    input  logic                      aclk,
    input  logic                      reset,
    input  logic                      op_valid,
    input  mem_op_e                   op,
    input  wb_req_t                   op_req,
    output logic                      op_done,
    output wb_rsp_t                   op_rdata,
    output logic                      fill_wen,
    output logic [`DCACHE_ADDR_W-1:0] fill_addr,
    output line_t                     fill_line,
    output logic                      mem_cyc,
    output logic                      mem_stb,
    output wb_req_t                   mem_req,
    input  logic                      mem_ack,
    input  wb_rsp_t                   mem_rsp
);

    logic [`DCACHE_OFFSET_W-3:0] beat_q;
    logic [`DCACHE_OFFSET_W-3:0] slot;
    logic                        is_fill;
    logic                        beat_ack;
    logic                        last_ack;
    line_t                       line_q;

    assign is_fill  = (op == MEM_FILL_LINE);
    assign beat_ack = mem_cyc && mem_stb && mem_ack;
    assign last_ack = beat_ack
                   && (!is_fill || beat_q == (`DCACHE_OFFSET_W-2)'(`DCACHE_BEATS - 1));

    // Single words land in their own slot, so one read path serves both cases
    assign slot = is_fill ? beat_q : op_req.adr[`DCACHE_OFFSET_W-1:2];

    // Bus request follows the held op, fills walk the aligned line
    always_comb begin
        mem_req    = op_req;
        mem_req.we = (op == MEM_WRITE_WORD);
        if (is_fill) begin
            mem_req.adr = {op_req.adr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], beat_q, 2'b00};
            mem_req.sel = '1;
        end
    end

    //////////////////////////////////////////////////
    // Cycle sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (reset) begin
            mem_cyc  <= 1'b0;
            mem_stb  <= 1'b0;
            beat_q   <= '0;
            op_done  <= 1'b0;
            fill_wen <= 1'b0;
        end else begin
            op_done  <= last_ack;
            fill_wen <= last_ack && is_fill;
            if (!mem_cyc) begin
                // No restart while the done pulse is still out
                if (op_valid && !op_done) begin
                    mem_cyc <= 1'b1;
                    mem_stb <= 1'b1;
                    beat_q  <= '0;
                end
            end else if (mem_stb) begin
                if (mem_ack) begin
                    mem_stb <= 1'b0;
                    beat_q  <= beat_q + 1'b1;
                    if (last_ack) begin
                        mem_cyc <= 1'b0;
                    end
                end
            end else begin
                // Next beat after one idle strobe cycle
                mem_stb <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (beat_ack) begin
            line_q[slot] <= mem_rsp.dat;
        end
    end

    assign op_rdata.dat = line_q[op_req.adr[`DCACHE_OFFSET_W-1:2]];
    assign fill_addr    = op_req.adr;
    assign fill_line    = line_q;

endmodule

/* verilog/dcache_top.sv */
//////////////////////////////////////////////////
// Data cache top: engine, blocks and memctrl
//////////////////////////////////////////////////

`include "dcache_defs.svh"

module dcache_top import dcache_pkg::*; (
    input  logic    aclk,
    input  logic    reset,
    output logic    cache_ready,
    // CPU Wishbone slave
    input  logic    cpu_cyc,
    input  logic    cpu_stb,
    input  wb_req_t cpu_req,
    output logic    cpu_ack,
    output wb_rsp_t cpu_rsp,
    // Memory Wishbone master
    output logic    mem_cyc,
    output logic    mem_stb,
    output wb_req_t mem_req,
    input  logic    mem_ack,
    input  wb_rsp_t mem_rsp
);

    logic [`DCACHE_ADDR_W-1:0] lookup_addr;
    logic                      upd_wen;
    wb_req_t                   upd_req;
    logic                      hit;
    wb_rsp_t                   hit_word;
    logic                      op_valid;
    mem_op_e                   op;
    wb_req_t                   op_req;
    logic                      op_done;
    wb_rsp_t                   op_rdata;
    logic                      fill_wen;
    logic [`DCACHE_ADDR_W-1:0] fill_addr;
    line_t                     fill_line;

    dcache_ctrl u_ctrl (
        .aclk        (aclk),
        .reset       (reset),
        .cpu_cyc     (cpu_cyc),
        .cpu_stb     (cpu_stb),
        .cpu_req     (cpu_req),
        .cpu_ack     (cpu_ack),
        .cpu_rsp     (cpu_rsp),
        .cache_ready (cache_ready),
        .hit         (hit),
        .hit_word    (hit_word),
        .lookup_addr (lookup_addr),
        .upd_wen     (upd_wen),
        .upd_req     (upd_req),
        .op_valid    (op_valid),
        .op          (op),
        .op_req      (op_req),
        .op_done     (op_done),
        .op_rdata    (op_rdata)
    );

    dcache_blocks u_blocks (
        .aclk        (aclk),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .upd_wen     (upd_wen),
        .upd_req     (upd_req),
        .fill_wen    (fill_wen),
        .fill_addr   (fill_addr),
        .fill_line   (fill_line),
        .hit         (hit),
        .hit_word    (hit_word),
        .cache_ready (cache_ready)
    );

    dcache_memctrl u_memctrl (
        .aclk      (aclk),
        .reset     (reset),
        .op_valid  (op_valid),
        .op        (op),
        .op_req    (op_req),
        .op_done   (op_done),
        .op_rdata  (op_rdata),
        .fill_wen  (fill_wen),
        .fill_addr (fill_addr),
        .fill_line (fill_line),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_rsp   (mem_rsp)
    );

endmodule

/* bench/tb_mem_model.sv */
//////////////////////////////////////////////////
// Wishbone slave memory with random wait states
//////////////////////////////////////////////////

`include "dcache_defs.svh"

module tb_mem_model import dcache_pkg::*; (
    input  logic    aclk,
    input  logic    reset,
    input  logic    cyc,
    input  logic    stb,
    input  wb_req_t req,
    output logic    ack,
    output wb_rsp_t rsp
);
    timeunit 1ns;
    timeprecision 1ns;

    localparam logic [31:0] SEED = 32'h17e3d11b;

    logic [7:0]  mem_bytes [logic [31:0]];
    int unsigned ack_count;
    int unsigned wait_left;

    // Never written bytes: low address byte plus 0x40, xor the upper address bytes
    function automatic logic [7:0] blank_byte(input logic [31:0] a);
        return (a[7:0] + 8'h40) ^ a[15:8] ^ a[23:16] ^ a[31:24];
    endfunction

    function automatic logic [31:0] peek_word(input logic [31:0] adr);
        logic [31:0] w;
        logic [31:0] a;
        for (int b = 0; b < `DCACHE_SEL_W; b++) begin
            a = {adr[31:2], 2'b00} + b;
            w[8*b +: 8] = mem_bytes.exists(a) ? mem_bytes[a] : blank_byte(a);
        end
        return w;
    endfunction

    // One process owns the generator, seeded once here
    initial begin
        ack       = 1'b0;
        rsp       = '0;
        ack_count = 0;
        wait_left = $urandom(SEED) % 4;
        forever begin
            @(posedge aclk);
            if (reset) begin
                ack       <= 1'b0;
                ack_count <= 0;
            end else if (ack) begin
                // Master drops stb on this edge
                ack <= 1'b0;
            end else if (cyc && stb) begin
                if (wait_left != 0) begin
                    wait_left--;
                end else begin
                    if (req.we) begin
                        for (int b = 0; b < `DCACHE_SEL_W; b++) begin
                            if (req.sel[b]) begin
                                mem_bytes[{req.adr[31:2], 2'b00} + b] = req.dat[8*b +: 8];
                            end
                        end
                    end
                    rsp.dat   <= peek_word(req.adr);
                    ack       <= 1'b1;
                    ack_count <= ack_count + 1;
                    wait_left = $urandom % 4;
                end
            end
        end
    end

endmodule

/* bench/tb_dcache.sv */
//////////////////////////////////////////////////
// Data cache testbench driving CPU accesses from patterns
//////////////////////////////////////////////////

`include "dcache_defs.svh"

module tb_dcache import dcache_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int READY_TIMEOUT = 200;
    localparam int ACK_TIMEOUT   = 100;
    localparam int MAX_ROWS      = 64;

    logic    aclk;
    logic    reset;
    logic    cache_ready;
    logic    cpu_cyc;
    logic    cpu_stb;
    wb_req_t cpu_req;
    logic    cpu_ack;
    wb_rsp_t cpu_rsp;
    logic    mem_cyc;
    logic    mem_stb;
    wb_req_t mem_req;
    logic    mem_ack;
    wb_rsp_t mem_rsp;

    // Each row packs op, address, data, select and expected
    logic [103:0] rows [MAX_ROWS];
    int           errors;
    int           tests;
    int           checks;

    dcache_top u_dut (
        .aclk        (aclk),
        .reset       (reset),
        .cache_ready (cache_ready),
        .cpu_cyc     (cpu_cyc),
        .cpu_stb     (cpu_stb),
        .cpu_req     (cpu_req),
        .cpu_ack     (cpu_ack),
        .cpu_rsp     (cpu_rsp),
        .mem_cyc     (mem_cyc),
        .mem_stb     (mem_stb),
        .mem_req     (mem_req),
        .mem_ack     (mem_ack),
        .mem_rsp     (mem_rsp)
    );

    tb_mem_model u_mem (
        .aclk  (aclk),
        .reset (reset),
        .cyc   (mem_cyc),
        .stb   (mem_stb),
        .req   (mem_req),
        .ack   (mem_ack),
        .rsp   (mem_rsp)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    //////////////////////////////////////////////////
    // CPU side driver
    //////////////////////////////////////////////////

    task automatic start_request(input logic we, input logic [31:0] addr,
                                 input logic [31:0] wdata, input logic [3:0] sel_bits);
        @(posedge aclk);
        cpu_cyc     <= 1'b1;
        cpu_stb     <= 1'b1;
        cpu_req.adr <= addr;
        cpu_req.dat <= wdata;
        cpu_req.sel <= sel_bits;
        cpu_req.we  <= we;
    endtask

    task automatic wait_ack(output logic [31:0] rdata, output logic ok);
        int n;
        n     = 0;
        ok    = 1'b0;
        rdata = '0;
        while (!ok && n < ACK_TIMEOUT) begin
            @(negedge aclk);
            n++;
            if (cpu_ack) begin
                ok    = 1'b1;
                rdata = cpu_rsp.dat;
            end
        end
        @(posedge aclk);
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
    endtask

    task automatic wait_ready(output logic ok, output logic early_ack);
        int n;
        n         = 0;
        early_ack = 1'b0;
        while (!cache_ready && n < READY_TIMEOUT) begin
            @(negedge aclk);
            n++;
            if (cpu_ack && !cache_ready) begin
                early_ack = 1'b1;
            end
        end
        ok = cache_ready;
    endtask

    //////////////////////////////////////////////////
    // Pattern sequencer
    //////////////////////////////////////////////////

    initial begin
        logic [3:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  sel_bits;
        logic [31:0] expected;
        logic [31:0] rdata;
        logic [31:0] cycles;
        logic [31:0] last_count;
        logic        ok;
        logic        early_ack;
        logic        row_ok;
        logic        table_end;
        logic        aborted;
        string       op_text;
        int          idx;

        reset   = 1'b1;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_req = '0;
        errors  = 0;
        tests   = 0;
        checks  = 0;
        for (int i = 0; i < MAX_ROWS; i++) begin
            rows[i] = '0;
        end
        $readmemh("bench/dcache_patterns.txt", rows);

        repeat (16) @(posedge aclk);
        reset <= 1'b0;

        last_count = 0;
        table_end  = 1'b0;
        aborted    = 1'b0;
        idx        = 0;
        while (!table_end && !aborted && idx < MAX_ROWS) begin
            {op, addr, wdata, sel_bits, expected} = rows[idx];
            row_ok = 1'b1;
            op_text = "";
            case (op)
                4'h1, 4'h2: begin
                    op_text = (op == 4'h2) ? "write" : "read";
                    start_request(op == 4'h2, addr, wdata, sel_bits);
                    ok = 1'b1;
                    if (idx == 0) begin
                        // First access goes out during the sweep and has to be held
                        @(negedge aclk);
                        checks++;
                        if (cache_ready !== 1'b0) begin
                            $display("CHECK FAILED cache_ready: expected %h got %h",
                                     1'b0, cache_ready);
                            errors++;
                            row_ok = 1'b0;
                        end
                        wait_ready(ok, early_ack);
                        if (!ok) begin
                            $display("cache_ready did not rise within %0d cycles",
                                     READY_TIMEOUT);
                        end else begin
                            checks++;
                            if (early_ack) begin
                                $display("cpu_ack came while cache_ready was still low");
                                errors++;
                                row_ok = 1'b0;
                            end
                        end
                    end
                    if (ok) begin
                        wait_ack(rdata, ok);
                        if (!ok) begin
                            $display("no cpu_ack for %s at %h within %0d cycles",
                                     op_text, addr, ACK_TIMEOUT);
                        end
                    end
                    if (!ok) begin
                        errors++;
                        row_ok  = 1'b0;
                        aborted = 1'b1;
                    end else if (op == 4'h1) begin
                        checks++;
                        if (rdata !== expected) begin
                            $display("CHECK FAILED cpu_rsp.dat: expected %h got %h",
                                     expected, rdata);
                            errors++;
                            row_ok = 1'b0;
                        end
                    end
                end
                4'h3: begin
                    op_text = "count";
                    @(negedge aclk);
                    cycles     = u_mem.ack_count - last_count;
                    last_count = u_mem.ack_count;
                    checks++;
                    if (cycles !== expected) begin
                        $display("CHECK FAILED mem_cycles: expected %h got %h",
                                 expected, cycles);
                        errors++;
                        row_ok = 1'b0;
                    end
                end
                4'h4: begin
                    op_text = "peek";
                    @(negedge aclk);
                    rdata = u_mem.peek_word(addr);
                    checks++;
                    if (rdata !== expected) begin
                        $display("CHECK FAILED mem_word: expected %h got %h",
                                 expected, rdata);
                        errors++;
                        row_ok = 1'b0;
                    end
                end
                default: begin
                    table_end = 1'b1;
                end
            endcase
            if (!table_end) begin
                tests++;
                $display("test %0d %s %h: %s", idx, op_text, addr, row_ok ? "ok" : "error");
            end
            idx++;
        end

        if (tests == 0) begin
            $display("pattern file holds no tests");
            errors++;
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* bench/dcache_patterns.txt */
// op_address_data_select_expected, all hex
// op 1 read, 2 write, 3 memory cycle count since last count, 4 memory word peek
// unwritten bytes: (addr[7:0] + 40) xor addr[15:8] xor addr[23:16] xor addr[31:24]
1_00000100_00000000_0_42434041 // early read, line fill
3_00000000_00000000_0_00000004
1_00000108_00000000_0_4A4B4849 // hits in the filled line
1_0000010C_00000000_0_4E4F4C4D
3_00000000_00000000_0_00000000
2_00000104_A5A5C3C3_5_00000000 // write hit, bytes 0 and 2
3_00000000_00000000_0_00000001
1_00000104_00000000_0_46A544C3
3_00000000_00000000_0_00000000
4_00000104_00000000_0_46A544C3
2_00000230_12345678_F_00000000 // write miss, no allocate
3_00000000_00000000_0_00000001
1_00000230_00000000_0_12345678
3_00000000_00000000_0_00000004
1_00000234_00000000_0_75747776
3_00000000_00000000_0_00000000
1_F0000010_00000000_0_A3A2A1A0 // uncached region
1_F0000010_00000000_0_A3A2A1A0
3_00000000_00000000_0_00000002
2_F0000010_DEADBEEF_3_00000000
1_F0000010_00000000_0_A3A2BEEF
3_00000000_00000000_0_00000002
4_F0000010_00000000_0_A3A2BEEF
1_00000500_00000000_0_46474445 // same index as 0x100, other tag
1_00000104_00000000_0_46A544C3
1_00000500_00000000_0_46474445
3_00000000_00000000_0_0000000C

/* all.f */
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_blocks.sv
verilog/dcache_ctrl.sv
verilog/dcache_memctrl.sv
verilog/dcache_top.sv
bench/tb_mem_model.sv
bench/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_pkg.sv
      - verilog/dcache_blocks.sv
      - verilog/dcache_ctrl.sv
      - verilog/dcache_memctrl.sv
      - verilog/dcache_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_mem_model.sv
      - bench/tb_dcache.sv
